/* logic/vid_adj_defines.svh */
/*
 * video colour-adjust constants
 * widths, APB register map, reset values and pipeline depth
 */
`ifndef VID_ADJ_DEFINES_SVH
`define VID_ADJ_DEFINES_SVH

// datapath widths
`define VA_PIX_W            8
`define VA_COE_W            9
`define VA_COE_FRAC         6
`define VA_CNT_W            20
`define VA_LAT              5

// APB register map
`define VA_ADDR_CTRL        8'h00
`define VA_ADDR_CONTRAST    8'h04
`define VA_ADDR_BRIGHT      8'h08
`define VA_ADDR_CLIP_LO     8'h0C
`define VA_ADDR_CLIP_HI     8'h10

// unity gain in Q3.6, no offset
`define VA_CONTRAST_RST     9'd64
`define VA_BRIGHT_RST       8'sd0

`endif

/* logic/vid_adj_pkg.sv */
/*
 * video colour-adjust types
 * video beat, coefficient set and APB request/response words
 */
`include "vid_adj_defines.svh"

package vid_adj_pkg;

    // --------------------
    // video stream
    // --------------------
    typedef struct packed {
        logic [`VA_PIX_W-1:0] r;
        logic [`VA_PIX_W-1:0] g;
        logic [`VA_PIX_W-1:0] b;
    } rgb_t;

    typedef struct packed {
        logic de;
        logic hs;
        logic vs;
        rgb_t pix;
    } vid_beat_t;

    // active coefficients, contrast is unsigned Q3.6
    typedef struct packed {
        logic [`VA_COE_W-1:0]        contrast;
        logic signed [`VA_PIX_W-1:0] bright;
        logic                        bypass;
    } adj_coef_t;

    // --------------------
    // APB
    // --------------------
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

/* logic/vid_adj_regs.sv */
/*
 * colour-adjust register file
 * APB slave with staging registers for contrast, brightness and bypass,
 * read-only clip counts, and a shadow copy that follows the staging
 * values on each rising vsync so a frame never sees a partial update
 */
`timescale 1ns/1ps
`include "vid_adj_defines.svh"

module vid_adj_regs import vid_adj_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  apb_req_t             apb_i,
    output apb_rsp_t             apb_o,
    input  logic                 vs_i,
    input  logic [`VA_CNT_W-1:0] clip_lo_cnt_i,
    input  logic [`VA_CNT_W-1:0] clip_hi_cnt_i,
    output adj_coef_t            coef_o
);

    localparam adj_coef_t COEF_RST = '{
        contrast: `VA_CONTRAST_RST,
        bright:   `VA_BRIGHT_RST,
        bypass:   1'b0
    };

    logic        setup;
    logic        access;
    logic        addr_hit;
    logic        addr_ro;
    logic [31:0] rdata;
    logic        wr_en;
    logic [31:0] prdata_q;
    logic        pslverr_q;
    adj_coef_t   stg_q;
    adj_coef_t   coef_q;
    logic        vs_d;
    logic        vs_rise;

    assign setup  = apb_i.psel & ~apb_i.penable;
    assign access = apb_i.psel & apb_i.penable;

    // --------------------
    // address decode
    // --------------------
    always_comb begin
        addr_hit = 1'b1;
        addr_ro  = 1'b0;
        rdata    = '0;
        case (apb_i.paddr)
            `VA_ADDR_CTRL:     rdata = 32'(stg_q.bypass);
            `VA_ADDR_CONTRAST: rdata = 32'(stg_q.contrast);
            // brightness reads back sign-extended
            `VA_ADDR_BRIGHT:   rdata = 32'($signed(stg_q.bright));
            `VA_ADDR_CLIP_LO: begin
                rdata   = 32'(clip_lo_cnt_i);
                addr_ro = 1'b1;
            end
            `VA_ADDR_CLIP_HI: begin
                rdata   = 32'(clip_hi_cnt_i);
                addr_ro = 1'b1;
            end
            default: addr_hit = 1'b0;
        endcase
    end

    assign wr_en = access & apb_i.pwrite & addr_hit & ~addr_ro;

    // staging registers, written at the end of the access cycle
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            stg_q <= COEF_RST;
        end else if (wr_en) begin
            case (apb_i.paddr)
                `VA_ADDR_CTRL:     stg_q.bypass   <= apb_i.pwdata[0];
                `VA_ADDR_CONTRAST: stg_q.contrast <= apb_i.pwdata[`VA_COE_W-1:0];
                `VA_ADDR_BRIGHT:   stg_q.bright   <= apb_i.pwdata[`VA_PIX_W-1:0];
                default: ;
            endcase
        end
    end

    // --------------------
    // response
    // --------------------
    // decided in setup, presented during access
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pslverr_q <= 1'b0;
        end else begin
            pslverr_q <= setup & (~addr_hit | (apb_i.pwrite & addr_ro));
        end
    end

    always_ff @(posedge clk) begin
        if (setup) begin
            prdata_q <= rdata;
        end
    end

    assign apb_o.prdata  = prdata_q;
    assign apb_o.pready  = 1'b1;
    assign apb_o.pslverr = pslverr_q;

    // --------------------
    // vsync shadow
    // --------------------
    assign vs_rise = vs_i & ~vs_d;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            vs_d   <= 1'b0;
            coef_q <= COEF_RST;
        end else begin
            vs_d <= vs_i;
            if (vs_rise) begin
                coef_q <= stg_q;
            end
        end
    end

    assign coef_o = coef_q;

    // access phase only ever follows a setup phase
    a_penable_after_psel: assert property (@(posedge clk) disable iff (!rst_n_i)
        apb_i.penable |-> $past(apb_i.psel));

    // registered error must land in the access cycle of its transfer
    a_slverr_in_access: assert property (@(posedge clk) disable iff (!rst_n_i)
        apb_o.pslverr |-> access);

endmodule

/* logic/bc_pipe.sv */
/*
 * brightness / contrast pipeline
 * five register stages per channel computing
 *   out = clamp((c * (p - 128) + 64 * (128 + b) + 32) >> 6)
 * with c unsigned Q3.6 and b signed; the input pixel rides a side
 * chain for bypass, and each output beat flags low or high clipping
 */
`timescale 1ns/1ps
`include "vid_adj_defines.svh"

module bc_pipe import vid_adj_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  adj_coef_t coef_i,
    input  vid_beat_t vid_i,
    output vid_beat_t vid_o,
    output logic      clip_lo_o,
    output logic      clip_hi_o
);

    localparam int PIX_W  = `VA_PIX_W;
    localparam int FRAC   = `VA_COE_FRAC;
    localparam int PROD_W = `VA_COE_W + `VA_PIX_W;
    localparam int ACC_W  = PROD_W + 2;
    localparam int SR_W   = `VA_LAT - 1;
    localparam logic signed [ACC_W-1:0] ROUND_HALF = ACC_W'(1 << (FRAC - 1));

    logic [PIX_W-1:0]        pix_in [3];
    logic [PIX_W-1:0]        byp_pix [3];
    // arithmetic stages
    logic [PROD_W-1:0]       s0_prod [3];
    logic [PROD_W-1:0]       s0_c128;
    logic signed [ACC_W-1:0] s0_ofs;
    logic signed [ACC_W-1:0] s1_diff [3];
    logic signed [ACC_W-1:0] s1_ofs;
    logic signed [ACC_W-1:0] s2_sum [3];
    logic signed [ACC_W-1:0] s3_rnd [3];
    logic [PIX_W-1:0]        clamp_pix [3];
    logic                    any_lo;
    logic                    any_hi;
    // side chains, bit 0 is stage 0
    logic [SR_W-1:0]         de_sr;
    logic [SR_W-1:0]         hs_sr;
    logic [SR_W-1:0]         vs_sr;
    logic [SR_W-1:0]         byp_sr;
    rgb_t                    pix_sr [SR_W];
    // output stage
    logic                    out_de;
    logic                    out_hs;
    logic                    out_vs;
    logic [PIX_W-1:0]        out_pix [3];
    logic                    clip_lo_q;
    logic                    clip_hi_q;

    assign pix_in[0]  = vid_i.pix.r;
    assign pix_in[1]  = vid_i.pix.g;
    assign pix_in[2]  = vid_i.pix.b;
    assign byp_pix[0] = pix_sr[SR_W-1].r;
    assign byp_pix[1] = pix_sr[SR_W-1].g;
    assign byp_pix[2] = pix_sr[SR_W-1].b;

    // --------------------
    // clamp
    // --------------------
    // any high channel wins over a low one for the beat flag
    always_comb begin
        any_lo = 1'b0;
        any_hi = 1'b0;
        for (int ch = 0; ch < 3; ch++) begin
            if (s3_rnd[ch][ACC_W-1]) begin
                clamp_pix[ch] = '0;
                any_lo        = 1'b1;
            end else if (|s3_rnd[ch][ACC_W-2:FRAC+PIX_W]) begin
                clamp_pix[ch] = '1;
                any_hi        = 1'b1;
            end else begin
                clamp_pix[ch] = s3_rnd[ch][FRAC +: PIX_W];
            end
        end
    end

    // --------------------
    // datapath
    // --------------------
    always_ff @(posedge clk) begin
        for (int ch = 0; ch < 3; ch++) begin
            // stage 0: products against this beat's own contrast
            s0_prod[ch] <= PROD_W'(coef_i.contrast) * PROD_W'(pix_in[ch]);
            // stage 1: remove the mid-grey term
            s1_diff[ch] <= $signed(ACC_W'(s0_prod[ch])) - $signed(ACC_W'(s0_c128));
            // stage 2: offset, stage 3: round half up
            s2_sum[ch]  <= s1_diff[ch] + s1_ofs;
            s3_rnd[ch]  <= s2_sum[ch] + ROUND_HALF;
            // stage 4
            out_pix[ch] <= byp_sr[SR_W-1] ? byp_pix[ch] : clamp_pix[ch];
        end
        s0_c128 <= PROD_W'(coef_i.contrast) << (PIX_W - 1);
        s0_ofs  <= (ACC_W'(128) + ACC_W'($signed(coef_i.bright))) <<< FRAC;
        s1_ofs  <= s0_ofs;
        pix_sr[0] <= vid_i.pix;
        for (int i = 1; i < SR_W; i++) begin
            pix_sr[i] <= pix_sr[i-1];
        end
    end

    // timing and flags
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            de_sr     <= '0;
            hs_sr     <= '0;
            vs_sr     <= '0;
            byp_sr    <= '0;
            out_de    <= 1'b0;
            out_hs    <= 1'b0;
            out_vs    <= 1'b0;
            clip_lo_q <= 1'b0;
            clip_hi_q <= 1'b0;
        end else begin
            de_sr     <= {de_sr[SR_W-2:0], vid_i.de};
            hs_sr     <= {hs_sr[SR_W-2:0], vid_i.hs};
            vs_sr     <= {vs_sr[SR_W-2:0], vid_i.vs};
            byp_sr    <= {byp_sr[SR_W-2:0], coef_i.bypass};
            out_de    <= de_sr[SR_W-1];
            out_hs    <= hs_sr[SR_W-1];
            out_vs    <= vs_sr[SR_W-1];
            clip_lo_q <= de_sr[SR_W-1] & ~byp_sr[SR_W-1] & any_lo & ~any_hi;
            clip_hi_q <= de_sr[SR_W-1] & ~byp_sr[SR_W-1] & any_hi;
        end
    end

    assign vid_o.de    = out_de;
    assign vid_o.hs    = out_hs;
    assign vid_o.vs    = out_vs;
    assign vid_o.pix.r = out_pix[0];
    assign vid_o.pix.g = out_pix[1];
    assign vid_o.pix.b = out_pix[2];
    assign clip_lo_o   = clip_lo_q;
    assign clip_hi_o   = clip_hi_q;

    // one flag per beat at most
    a_clip_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(clip_lo_o && clip_hi_o));

    // flags only ever mark active output pixels
    a_clip_de: assert property (@(posedge clk) disable iff (!rst_n_i)
        (clip_lo_o || clip_hi_o) |-> vid_o.de);

endmodule

/* logic/clip_stats.sv */
/*
 * per-frame clip statistics
 * counts low-clipped and high-clipped output pixels, saturating,
 * and latches both counts on the rising vsync that ends a frame
 */
`timescale 1ns/1ps
`include "vid_adj_defines.svh"

module clip_stats (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 vs_i,
    input  logic                 clip_lo_i,
    input  logic                 clip_hi_i,
    output logic [`VA_CNT_W-1:0] clip_lo_cnt_o,
    output logic [`VA_CNT_W-1:0] clip_hi_cnt_o
);

    localparam int CNT_W = `VA_CNT_W;

    logic             vs_d;
    logic             vs_rise;
    // index 0 is low clip, 1 is high clip
    logic [1:0]       hit;
    logic [CNT_W-1:0] run_q [2];
    logic [CNT_W-1:0] lat_q [2];

    assign vs_rise = vs_i & ~vs_d;
    assign hit     = {clip_hi_i, clip_lo_i};

    // --------------------
    // counters
    // --------------------
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            vs_d <= 1'b0;
            for (int i = 0; i < 2; i++) begin
                run_q[i] <= '0;
                lat_q[i] <= '0;
            end
        end else begin
            vs_d <= vs_i;
            for (int i = 0; i < 2; i++) begin
                if (vs_rise) begin
                    // frame boundary, a hit here belongs to the new frame
                    lat_q[i] <= run_q[i];
                    run_q[i] <= CNT_W'(hit[i]);
                end else if (hit[i] && (run_q[i] != '1)) begin
                    run_q[i] <= run_q[i] + 1'b1;
                end
            end
        end
    end

    // latched values hold until the next frame ends
    assign clip_lo_cnt_o = lat_q[0];
    assign clip_hi_cnt_o = lat_q[1];

endmodule

/* logic/vid_adj_top.sv */
/*
 * video colour-adjust top level
 * APB register file, five-cycle brightness/contrast pipeline and
 * per-frame clip statistics
 */
`timescale 1ns/1ps
`include "vid_adj_defines.svh"

module vid_adj_top import vid_adj_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  apb_req_t  apb_i,
    output apb_rsp_t  apb_o,
    input  vid_beat_t vid_i,
    output vid_beat_t vid_o
);

    adj_coef_t            coef;
    logic                 clip_lo;
    logic                 clip_hi;
    logic [`VA_CNT_W-1:0] clip_lo_cnt;
    logic [`VA_CNT_W-1:0] clip_hi_cnt;

    // shadow load follows vsync at the pipeline input
    vid_adj_regs u_regs (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .apb_i         (apb_i),
        .apb_o         (apb_o),
        .vs_i          (vid_i.vs),
        .clip_lo_cnt_i (clip_lo_cnt),
        .clip_hi_cnt_i (clip_hi_cnt),
        .coef_o        (coef)
    );

    bc_pipe u_pipe (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .coef_i    (coef),
        .vid_i     (vid_i),
        .vid_o     (vid_o),
        .clip_lo_o (clip_lo),
        .clip_hi_o (clip_hi)
    );

    // frame boundaries taken from the output side
    clip_stats u_stats (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .vs_i          (vid_o.vs),
        .clip_lo_i     (clip_lo),
        .clip_hi_i     (clip_hi),
        .clip_lo_cnt_o (clip_lo_cnt),
        .clip_hi_cnt_o (clip_hi_cnt)
    );

endmodule

/* tb/vid_adj_checker.sv */
/*
 * video colour-adjust checker
 * models the register file and vsync shadow from observed APB traffic,
 * predicts each output pixel and the per-frame clip counts
 */
`timescale 1ns/1ps
`include "vid_adj_defines.svh"

module vid_adj_checker import vid_adj_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  apb_req_t  apb_req_i,
    input  apb_rsp_t  apb_rsp_i,
    input  vid_beat_t vid_in_i,
    input  vid_beat_t vid_out_i,
    output int        errors_o,
    output int        checks_o,
    output int        pending_o
);

    localparam int MID     = 1 << (`VA_PIX_W - 1);
    localparam int UNITY   = 1 << `VA_COE_FRAC;
    localparam int PIX_MAX = (1 << `VA_PIX_W) - 1;

    typedef struct packed {
        rgb_t pix;
        logic lo;
        logic hi;
    } exp_beat_t;

    adj_coef_t   stg;
    adj_coef_t   act;
    exp_beat_t   exp_q [$];
    exp_beat_t   head;
    logic [2:0]  sync_hist [`VA_LAT];
    logic        vs_in_d;
    logic        vs_out_d;
    int          run_lo;
    int          run_hi;
    int          lat_lo;
    int          lat_hi;
    logic [31:0] exp_rdata;
    logic        exp_err;

    // contrast around mid-grey, then brightness, round half up and clamp
    function automatic exp_beat_t ref_beat(rgb_t p, adj_coef_t c);
        exp_beat_t            e;
        logic [`VA_PIX_W-1:0] ch [3];
        int                   v;
        ch[0] = p.r;
        ch[1] = p.g;
        ch[2] = p.b;
        e = '0;
        for (int k = 0; k < 3; k++) begin
            v = int'(c.contrast) * (int'(ch[k]) - MID)
                + UNITY * (MID + int'($signed(c.bright))) + UNITY / 2;
            v = v >>> `VA_COE_FRAC;
            if (v < 0) begin
                ch[k] = '0;
                e.lo  = 1'b1;
            end else if (v > PIX_MAX) begin
                ch[k] = '1;
                e.hi  = 1'b1;
            end else begin
                ch[k] = v[`VA_PIX_W-1:0];
            end
        end
        e.pix = '{r: ch[0], g: ch[1], b: ch[2]};
        // high wins when a beat clips both ways
        e.lo = e.lo & ~e.hi;
        if (c.bypass) begin
            e = '{pix: p, lo: 1'b0, hi: 1'b0};
        end
        return e;
    endfunction

    always @(posedge clk) begin
        if (!rst_n_i) begin
            stg = '{contrast: `VA_CONTRAST_RST, bright: `VA_BRIGHT_RST, bypass: 1'b0};
            act = stg;
            exp_q.delete();
            sync_hist = '{default: '0};
            {vs_in_d, vs_out_d, exp_err, exp_rdata} = '0;
            {run_lo, run_hi, lat_lo, lat_hi} = '0;
            {errors_o, checks_o, pending_o} = '0;
        end else begin
            // --------------------
            // APB expectation fixed in setup
            // --------------------
            if (apb_req_i.psel && !apb_req_i.penable) begin
                exp_err   = 1'b0;
                exp_rdata = '0;
                case (apb_req_i.paddr)
                    `VA_ADDR_CTRL:     exp_rdata = 32'(stg.bypass);
                    `VA_ADDR_CONTRAST: exp_rdata = 32'(stg.contrast);
                    `VA_ADDR_BRIGHT:   exp_rdata = {{24{stg.bright[7]}}, stg.bright};
                    `VA_ADDR_CLIP_LO: begin
                        exp_rdata = 32'(lat_lo);
                        exp_err   = apb_req_i.pwrite;
                    end
                    `VA_ADDR_CLIP_HI: begin
                        exp_rdata = 32'(lat_hi);
                        exp_err   = apb_req_i.pwrite;
                    end
                    default: exp_err = 1'b1;
                endcase
            end
            if (apb_req_i.psel && apb_req_i.penable) begin
                checks_o++;
                if (apb_rsp_i.pready !== 1'b1) begin
                    errors_o++;
                    $display("ERR %0t: pready %b at address %h, expected 1", $time,
                             apb_rsp_i.pready, apb_req_i.paddr);
                end
                if (apb_rsp_i.pslverr !== exp_err) begin
                    errors_o++;
                    $display("ERR %0t: pslverr %b at address %h, expected %b", $time,
                             apb_rsp_i.pslverr, apb_req_i.paddr, exp_err);
                end else if (!apb_req_i.pwrite && !exp_err
                             && apb_rsp_i.prdata !== exp_rdata) begin
                    errors_o++;
                    $display("ERR %0t: read of %h gave %h, expected %h", $time,
                             apb_req_i.paddr, apb_rsp_i.prdata, exp_rdata);
                end
            end

            // --------------------
            // input side
            // --------------------
            if (vid_in_i.de) begin
                exp_q.push_back(ref_beat(vid_in_i.pix, act));
            end
            // shadow takes the staging values from before this cycle's write
            if (vid_in_i.vs && !vs_in_d) begin
                act = stg;
            end
            vs_in_d = vid_in_i.vs;
            if (apb_req_i.psel && apb_req_i.penable && apb_req_i.pwrite && !exp_err) begin
                case (apb_req_i.paddr)
                    `VA_ADDR_CTRL:     stg.bypass   = apb_req_i.pwdata[0];
                    `VA_ADDR_CONTRAST: stg.contrast = apb_req_i.pwdata[`VA_COE_W-1:0];
                    `VA_ADDR_BRIGHT:   stg.bright   = apb_req_i.pwdata[`VA_PIX_W-1:0];
                    default: ;
                endcase
            end

            // --------------------
            // output side
            // --------------------
            checks_o++;
            if ({vid_out_i.de, vid_out_i.hs, vid_out_i.vs} !== sync_hist[`VA_LAT-1]) begin
                errors_o++;
                $display("ERR %0t: de/hs/vs %b, expected %b", $time,
                         {vid_out_i.de, vid_out_i.hs, vid_out_i.vs}, sync_hist[`VA_LAT-1]);
            end
            for (int k = `VA_LAT - 1; k > 0; k--) begin
                sync_hist[k] = sync_hist[k-1];
            end
            sync_hist[0] = {vid_in_i.de, vid_in_i.hs, vid_in_i.vs};

            // frame end makes the counts readable
            if (vid_out_i.vs && !vs_out_d) begin
                lat_lo = run_lo;
                lat_hi = run_hi;
                run_lo = 0;
                run_hi = 0;
            end
            vs_out_d = vid_out_i.vs;
            if (vid_out_i.de) begin
                if (exp_q.size() == 0) begin
                    errors_o++;
                    $display("output pixel at %0t has no matching input pixel", $time);
                end else begin
                    head = exp_q.pop_front();
                    checks_o++;
                    if (vid_out_i.pix !== head.pix) begin
                        errors_o++;
                        $display("ERR %0t: pixel %h, expected %h", $time,
                                 vid_out_i.pix, head.pix);
                    end
                    run_lo += int'(head.lo);
                    run_hi += int'(head.hi);
                end
            end
            pending_o = exp_q.size();
        end
    end

endmodule

/* tb/tb_vid_adj.sv */
/*
 * testbench for the video colour-adjust block
 * register access, pass-through, random coefficients, saturation and
 * bypass over small frames; the checker does all comparisons
 */
`timescale 1ns/1ps
`include "vid_adj_defines.svh"

module tb_vid_adj import vid_adj_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int ACT_W      = 16;
    localparam int LINES      = 4;
    localparam int HS_LEN     = 2;
    localparam int H_PORCH    = 2;
    localparam int VS_LEN     = 3;
    localparam int V_PORCH    = 6;
    localparam int LINE_CYC   = HS_LEN + 2 * H_PORCH + ACT_W;
    localparam int FRAME_CYC  = VS_LEN + V_PORCH + LINES * LINE_CYC;
    // frames over all tests including the closing vsyncs
    localparam int NUM_FRAMES = 16;
    localparam int MARGIN_CYC = 2000;
    localparam int TIMEOUT_NS = (NUM_FRAMES * FRAME_CYC + MARGIN_CYC) * CLK_PERIOD;

    logic      clk;
    logic      rst_n;
    apb_req_t  apb_req;
    apb_rsp_t  apb_rsp;
    vid_beat_t vid_in;
    vid_beat_t vid_out;
    int        errors;
    int        checks;
    int        pending;
    int        n_pass;
    int        n_fail;

    vid_adj_top UUT (
        .clk     (clk),
        .rst_n_i (rst_n),
        .apb_i   (apb_req),
        .apb_o   (apb_rsp),
        .vid_i   (vid_in),
        .vid_o   (vid_out)
    );

    vid_adj_checker u_checker (
        .clk       (clk),
        .rst_n_i   (rst_n),
        .apb_req_i (apb_req),
        .apb_rsp_i (apb_rsp),
        .vid_in_i  (vid_in),
        .vid_out_i (vid_out),
        .errors_o  (errors),
        .checks_o  (checks),
        .pending_o (pending)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: run did not complete within %0d ns", TIMEOUT_NS);
        $display("Verification failed");
        $finish;
    end

    // --------------------
    // stimulus tasks
    // --------------------
    task automatic drive_beat(input logic de, input logic hs, input logic vs, input rgb_t pix);
        @(posedge clk);
        #2;
        vid_in = '{de: de, hs: hs, vs: vs, pix: pix};
    endtask

    task automatic idle(input int n);
        repeat (n) drive_beat(1'b0, 1'b0, 1'b0, '0);
    endtask

    // empty vsync pulse that ends the previous frame at the output
    task automatic close_frame();
        repeat (VS_LEN) drive_beat(1'b0, 1'b0, 1'b1, '0);
        idle(2 * `VA_LAT);
    endtask

    task automatic send_frame();
        rgb_t px;
        repeat (VS_LEN) drive_beat(1'b0, 1'b0, 1'b1, '0);
        idle(V_PORCH);
        for (int ln = 0; ln < LINES; ln++) begin
            repeat (HS_LEN) drive_beat(1'b0, 1'b1, 1'b0, '0);
            idle(H_PORCH);
            for (int i = 0; i < ACT_W; i++) begin
                px = 24'($urandom());
                drive_beat(1'b1, 1'b0, 1'b0, px);
            end
            idle(H_PORCH);
        end
    endtask

    // two-cycle transfer since pready is tied high
    task automatic apb_transfer(input logic wr, input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        #2;
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: data};
        @(posedge clk);
        #2;
        apb_req.penable = 1'b1;
        @(posedge clk);
        #2;
        apb_req = '0;
    endtask

    task automatic write_coef(input int contrast, input int bright);
        apb_transfer(1'b1, `VA_ADDR_CONTRAST, 32'(contrast));
        apb_transfer(1'b1, `VA_ADDR_BRIGHT, 32'(bright));
    endtask

    task automatic read_clip_counts();
        apb_transfer(1'b0, `VA_ADDR_CLIP_LO, '0);
        apb_transfer(1'b0, `VA_ADDR_CLIP_HI, '0);
    endtask

    task automatic finish_test(input string name, input int err_before);
        idle(2 * `VA_LAT);
        if (errors == err_before) begin
            n_pass++;
            $display("test %s: ok", name);
        end else begin
            n_fail++;
            $display("test %s: FAILED with %0d errors", name, errors - err_before);
        end
    endtask

    // --------------------
    // test sequence
    // --------------------
    initial begin
        int err0;
        void'($urandom(6));
        apb_req = '0;
        vid_in  = '0;
        rst_n   = 1'b0;
        n_pass  = 0;
        n_fail  = 0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;

        err0 = errors;
        for (int a = 0; a <= 16; a += 4) begin
            apb_transfer(1'b0, 8'(a), '0);
        end
        apb_transfer(1'b0, 8'h14, '0);
        apb_transfer(1'b1, 8'h20, 32'h5a);
        apb_transfer(1'b1, `VA_ADDR_CLIP_LO, 32'h1);
        apb_transfer(1'b0, `VA_ADDR_CLIP_LO, '0);
        finish_test("1 reset values and slave errors", err0);

        err0 = errors;
        repeat (2) send_frame();
        finish_test("2 unity pass-through", err0);

        err0 = errors;
        for (int f = 0; f < 6; f++) begin
            if (f % 2 == 0) begin
                write_coef($urandom_range(0, 511), $urandom_range(0, 255));
            end
            fork
                send_frame();
                begin
                    // staged now and used from the next frame
                    repeat ($urandom_range(20, 80)) @(posedge clk);
                    write_coef($urandom_range(0, 511), $urandom_range(0, 255));
                end
            join
        end
        close_frame();
        read_clip_counts();
        finish_test("3 random coefficients", err0);

        err0 = errors;
        write_coef(511, 0);
        send_frame();
        close_frame();
        read_clip_counts();
        write_coef(511, -128);
        send_frame();
        close_frame();
        read_clip_counts();
        finish_test("4 saturation and clip counts", err0);

        err0 = errors;
        apb_transfer(1'b1, `VA_ADDR_CTRL, 32'h1);
        // strong gain and offset that would clip both ways without bypass
        write_coef(511, 127);
        send_frame();
        close_frame();
        read_clip_counts();
        apb_transfer(1'b0, `VA_ADDR_CTRL, '0);
        apb_transfer(1'b1, `VA_ADDR_CTRL, 32'h0);
        finish_test("5 bypass", err0);

        idle(2 * `VA_LAT);
        if (pending != 0) begin
            n_fail++;
            $display("%0d expected pixels never left the pipeline", pending);
        end
        $display("tests passed: %0d, failed: %0d, checks: %0d, errors: %0d",
                 n_pass, n_fail, checks, errors);
        if (n_fail == 0 && errors == 0 && checks > 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+logic
logic/vid_adj_pkg.sv
logic/vid_adj_regs.sv
logic/bc_pipe.sv
logic/clip_stats.sv
logic/vid_adj_top.sv
tb/vid_adj_checker.sv
tb/tb_vid_adj.sv

/* Makefile */
# Verilator build and run for the video colour-adjust block

VERILATOR ?= verilator
TOP       ?= tb_vid_adj
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
PASS_MSG  ?= Verification passed

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := $(wildcard logic/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean
.DELETE_ON_ERROR:

all: check

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

$(LOG): $(BIN)
	$(BIN) > $(LOG) 2>&1

run: $(BIN)
	$(BIN) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

check: $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
